/* filelist.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/l1d_wb_if.sv
rtl/l1d_dirty_tracker.sv
rtl/l1i_tag_store.sv
rtl/l2_flush_engine.sv
rtl/flush_sequencer.sv
rtl/cache_flush_top.sv
tests/cache_flush_assert.sv
tests/cache_flush_tb.sv

/* rtl/cache_flush_top.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_flush_top
(
   input logic                        clk,
   input logic                        reset,
   input logic                        store_valid,
   input logic [`LG_L2_LINES-1:0]     store_line,
   input logic                        fetch_valid,
   input logic [`LG_FETCH_LINES-1:0]  fetch_line,
   input logic                        flush_req_l1d,
   input logic                        flush_req_l1i,
   input logic                        mem_rsp_valid,
   output logic                       fetch_hit_valid,
   output logic                       fetch_hit,
   output logic                       mem_req_valid,
   output logic [`MEM_ADDR_WIDTH-1:0] mem_req_addr,
   output logic                       in_flush_mode,
   output logic                       flush_done
);

   logic l1i_flush_complete;
   logic l2_flush_start;
   logic l2_flush_complete;

   l1d_wb_if l1d_bus();

   assign l1d_bus.flush_req = flush_req_l1d;

   l1d_dirty_tracker l1d
   (
      .clk(clk),
      .reset(reset),
      .store_valid(store_valid),
      .store_line(store_line),
      .wb(l1d_bus.tracker)
   );

   l1i_tag_store l1i
   (
      .clk(clk),
      .reset(reset),
      .fetch_valid(fetch_valid),
      .fetch_line(fetch_line),
      .fetch_hit_valid(fetch_hit_valid),
      .fetch_hit(fetch_hit),
      .flush_req(flush_req_l1i),
      .flush_complete(l1i_flush_complete)
   );

   l2_flush_engine l2
   (
      .clk(clk),
      .reset(reset),
      .wb(l1d_bus.l2),
      .flush_start(l2_flush_start),
      .flush_complete(l2_flush_complete),
      .mem_req_valid(mem_req_valid),
      .mem_req_addr(mem_req_addr),
      .mem_rsp_valid(mem_rsp_valid)
   );

   flush_sequencer seq
   (
      .clk(clk),
      .reset(reset),
      .l1d(l1d_bus.seq),
      .l1i_flush_req(flush_req_l1i),
      .l1i_flush_complete(l1i_flush_complete),
      .l2_flush_start(l2_flush_start),
      .l2_flush_complete(l2_flush_complete),
      .in_flush_mode(in_flush_mode),
      .flush_done(flush_done)
   );

endmodule

/* rtl/cache_pkg.sv */
package cache_pkg;

   typedef enum logic [2:0] {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,
      GOT_L1I          = 3'd3,
      FLUSH_L2         = 3'd4
   } flush_state_t;

   typedef enum logic [0:0] {
      WALK_IDLE = 1'b0,
      WALK_SCAN = 1'b1
   } walk_state_t;

   typedef enum logic [1:0] {
      L2_IDLE     = 2'd0,
      L2_SCAN     = 2'd1,
      L2_WAIT_RSP = 2'd2
   } l2_state_t;

endpackage

/* rtl/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// direct mapped L1D, 16 lines
`define LG_L1D_LINES 4
// direct mapped L1I, 32 lines
`define LG_L1I_LINES 5
// L2 covers the whole store address space
`define LG_L2_LINES 6
`define LG_FETCH_LINES 8

`define LG_LINE_BYTES 4
`define MEM_ADDR_WIDTH 32

`endif

/* rtl/flush_sequencer.sv */
`timescale 1ns/100ps

module flush_sequencer
(
   input logic   clk,
   input logic   reset,
   l1d_wb_if.seq l1d,
   input logic   l1i_flush_req,
   input logic   l1i_flush_complete,
   output logic  l2_flush_start,
   input logic   l2_flush_complete,
   output logic  in_flush_mode,
   output logic  flush_done
);

   cache_pkg::flush_state_t r_state, n_state;
   logic r_flush, n_flush;
   logic r_flush_l2, n_flush_l2;

   assign in_flush_mode = r_flush;
   assign l2_flush_start = r_flush_l2;

   // last cycle of flush mode
   assign flush_done = (r_state == cache_pkg::FLUSH_L2) && l2_flush_complete;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= cache_pkg::FLUSH_IDLE;
         r_flush <= 1'b0;
         r_flush_l2 <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_flush <= n_flush;
         r_flush_l2 <= n_flush_l2;
      end
   end

   always_comb
   begin
      n_state = r_state;
      n_flush = r_flush;
      n_flush_l2 = 1'b0;
      case (r_state)
         cache_pkg::FLUSH_IDLE:
         begin
            n_flush = l1d.flush_req || l1i_flush_req;
            if (l1d.flush_req && l1i_flush_req)
               n_state = cache_pkg::WAIT_FOR_L1D_L1I;
            else if (l1i_flush_req)
               n_state = cache_pkg::GOT_L1D; // L1D not requested
            else if (l1d.flush_req)
               n_state = cache_pkg::GOT_L1I;
         end
         cache_pkg::WAIT_FOR_L1D_L1I:
         begin
            if (l1d.flush_complete && l1i_flush_complete)
            begin
               n_state = cache_pkg::FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
            else if (l1d.flush_complete)
               n_state = cache_pkg::GOT_L1D;
            else if (l1i_flush_complete)
               n_state = cache_pkg::GOT_L1I;
         end
         cache_pkg::GOT_L1D:
         begin
            if (l1i_flush_complete)
            begin
               n_state = cache_pkg::FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         cache_pkg::GOT_L1I:
         begin
            if (l1d.flush_complete)
            begin
               n_state = cache_pkg::FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         cache_pkg::FLUSH_L2:
         begin
            if (l2_flush_complete)
            begin
               n_state = cache_pkg::FLUSH_IDLE;
               n_flush = 1'b0;
            end
         end
         default:
         begin
            n_state = cache_pkg::FLUSH_IDLE;
         end
      endcase
   end

endmodule

/* rtl/l1d_dirty_tracker.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module l1d_dirty_tracker
(
   input logic                    clk,
   input logic                    reset,
   input logic                    store_valid,
   input logic [`LG_L2_LINES-1:0] store_line,
   l1d_wb_if.tracker              wb
);

   localparam L1D_LINES = 1 << `LG_L1D_LINES;
   localparam TAG_W = `LG_L2_LINES - `LG_L1D_LINES;

   cache_pkg::walk_state_t r_state;

   logic [`LG_L1D_LINES-1:0] r_ptr;
   logic [L1D_LINES-1:0]     r_valid;
   logic [L1D_LINES-1:0]     r_dirty;
   logic [TAG_W-1:0]         r_tag [L1D_LINES];

   logic                    r_wb_valid;
   logic [`LG_L2_LINES-1:0] r_wb_line;
   logic                    r_complete;

   logic [`LG_L1D_LINES-1:0] w_idx;
   logic [TAG_W-1:0]         w_tag;
   logic                     w_evict;
   logic                     w_store;

   assign w_idx = store_line[`LG_L1D_LINES-1:0];
   assign w_tag = store_line[`LG_L2_LINES-1:`LG_L1D_LINES];
   assign w_store = store_valid && (r_state == cache_pkg::WALK_IDLE);

   // dirty line with another tag gets displaced
   assign w_evict = r_valid[w_idx] && r_dirty[w_idx] && (r_tag[w_idx] != w_tag);

   assign wb.wb_valid = r_wb_valid;
   assign wb.wb_line = r_wb_line;
   assign wb.flush_complete = r_complete;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= cache_pkg::WALK_IDLE;
         r_ptr <= '0;
         r_valid <= '0;
         r_dirty <= '0;
         r_wb_valid <= 1'b0;
         r_complete <= 1'b0;
      end
      else
      begin
         r_wb_valid <= 1'b0;
         r_complete <= 1'b0;
         case (r_state)
            cache_pkg::WALK_IDLE:
            begin
               if (w_store)
               begin
                  r_valid[w_idx] <= 1'b1;
                  r_dirty[w_idx] <= 1'b1;
                  r_wb_valid <= w_evict;
               end
               if (wb.flush_req)
               begin
                  r_state <= cache_pkg::WALK_SCAN;
                  r_ptr <= '0;
               end
            end
            cache_pkg::WALK_SCAN:
            begin
               // one line per cycle, dirty ones go to L2
               r_wb_valid <= r_valid[r_ptr] && r_dirty[r_ptr];
               r_valid[r_ptr] <= 1'b0;
               r_dirty[r_ptr] <= 1'b0;
               r_ptr <= r_ptr + 1'b1;
               if (&r_ptr) // last line
               begin
                  r_state <= cache_pkg::WALK_IDLE;
                  r_complete <= 1'b1;
               end
            end
            default:
            begin
               r_state <= cache_pkg::WALK_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (w_store)
      begin
         r_tag[w_idx] <= w_tag;
         r_wb_line <= {r_tag[w_idx], w_idx}; // old line
      end
      else if (r_state == cache_pkg::WALK_SCAN)
      begin
         r_wb_line <= {r_tag[r_ptr], r_ptr};
      end
   end

endmodule

/* rtl/l1d_wb_if.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

interface l1d_wb_if;

   logic                    flush_req;      // pulse
   logic                    flush_complete; // pulse
   logic                    wb_valid;       // pulse, never stalled
   logic [`LG_L2_LINES-1:0] wb_line;

   modport tracker
   (
      input  flush_req,
      output flush_complete,
      output wb_valid,
      output wb_line
   );

   modport l2 (input wb_valid, input wb_line);

   modport seq (input flush_req, input flush_complete);

endinterface

/* rtl/l1i_tag_store.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module l1i_tag_store
(
   input logic                       clk,
   input logic                       reset,
   input logic                       fetch_valid,
   input logic [`LG_FETCH_LINES-1:0] fetch_line,
   output logic                      fetch_hit_valid,
   output logic                      fetch_hit,
   input logic                       flush_req,
   output logic                      flush_complete
);

   localparam L1I_LINES = 1 << `LG_L1I_LINES;
   localparam TAG_W = `LG_FETCH_LINES - `LG_L1I_LINES;

   cache_pkg::walk_state_t r_state;

   logic [`LG_L1I_LINES-1:0] r_ptr;
   logic [L1I_LINES-1:0]     r_valid;
   logic [TAG_W-1:0]         r_tag [L1I_LINES];
   logic                     r_hit_valid;
   logic                     r_hit;
   logic                     r_complete;

   logic [`LG_L1I_LINES-1:0] w_idx;
   logic [TAG_W-1:0]         w_tag;
   logic                     w_hit;
   logic                     w_fill;

   assign w_idx = fetch_line[`LG_L1I_LINES-1:0];
   assign w_tag = fetch_line[`LG_FETCH_LINES-1:`LG_L1I_LINES];
   assign w_hit = r_valid[w_idx] && (r_tag[w_idx] == w_tag);

   // miss fills the line at once, no fills during the scan
   assign w_fill = fetch_valid && !w_hit && (r_state == cache_pkg::WALK_IDLE);

   assign fetch_hit_valid = r_hit_valid;
   assign fetch_hit = r_hit;
   assign flush_complete = r_complete;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= cache_pkg::WALK_IDLE;
         r_ptr <= '0;
         r_valid <= '0;
         r_hit_valid <= 1'b0;
         r_complete <= 1'b0;
      end
      else
      begin
         r_hit_valid <= fetch_valid;
         r_complete <= 1'b0;
         if (w_fill)
            r_valid[w_idx] <= 1'b1;
         case (r_state)
            cache_pkg::WALK_IDLE:
            begin
               if (flush_req)
               begin
                  r_state <= cache_pkg::WALK_SCAN;
                  r_ptr <= '0;
               end
            end
            cache_pkg::WALK_SCAN:
            begin
               r_valid[r_ptr] <= 1'b0;
               r_ptr <= r_ptr + 1'b1;
               if (&r_ptr)
               begin
                  r_state <= cache_pkg::WALK_IDLE;
                  r_complete <= 1'b1;
               end
            end
            default:
            begin
               r_state <= cache_pkg::WALK_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_valid)
         r_hit <= w_hit;
      if (w_fill)
         r_tag[w_idx] <= w_tag;
   end

endmodule

/* rtl/l2_flush_engine.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module l2_flush_engine
(
   input logic                        clk,
   input logic                        reset,
   l1d_wb_if.l2                       wb,
   input logic                        flush_start,
   output logic                       flush_complete,
   output logic                       mem_req_valid,
   output logic [`MEM_ADDR_WIDTH-1:0] mem_req_addr,
   input logic                        mem_rsp_valid
);

   localparam L2_LINES = 1 << `LG_L2_LINES;
   localparam ADDR_PAD = `MEM_ADDR_WIDTH - `LG_L2_LINES - `LG_LINE_BYTES;

   cache_pkg::l2_state_t r_state;

   logic [`LG_L2_LINES-1:0]    r_ptr;
   logic [L2_LINES-1:0]        r_dirty;
   logic                       r_req_valid;
   logic [`MEM_ADDR_WIDTH-1:0] r_req_addr;
   logic                       r_complete;

   logic w_issue;

   // dirty line found while walking
   assign w_issue = (r_state == cache_pkg::L2_SCAN) && r_dirty[r_ptr];

   assign mem_req_valid = r_req_valid;
   assign mem_req_addr = r_req_addr;
   assign flush_complete = r_complete;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= cache_pkg::L2_IDLE;
         r_ptr <= '0;
         r_dirty <= '0;
         r_req_valid <= 1'b0;
         r_complete <= 1'b0;
      end
      else
      begin
         r_req_valid <= 1'b0;
         r_complete <= 1'b0;
         case (r_state)
            cache_pkg::L2_IDLE:
            begin
               if (flush_start)
               begin
                  r_state <= cache_pkg::L2_SCAN;
                  r_ptr <= '0;
               end
            end
            cache_pkg::L2_SCAN:
            begin
               if (w_issue)
               begin
                  r_dirty[r_ptr] <= 1'b0;
                  r_req_valid <= 1'b1;
                  r_state <= cache_pkg::L2_WAIT_RSP;
               end
               else if (&r_ptr)
               begin
                  r_state <= cache_pkg::L2_IDLE;
                  r_complete <= 1'b1;
               end
               else
                  r_ptr <= r_ptr + 1'b1;
            end
            cache_pkg::L2_WAIT_RSP:
            begin
               if (mem_rsp_valid && (&r_ptr))
               begin
                  r_state <= cache_pkg::L2_IDLE;
                  r_complete <= 1'b1;
               end
               else if (mem_rsp_valid)
               begin
                  r_state <= cache_pkg::L2_SCAN;
                  r_ptr <= r_ptr + 1'b1;
               end
            end
            default:
            begin
               r_state <= cache_pkg::L2_IDLE;
            end
         endcase
         if (wb.wb_valid)
            r_dirty[wb.wb_line] <= 1'b1; // wins over the walk clear
      end
   end

   always_ff @(posedge clk)
   begin
      if (w_issue)
         r_req_addr <= {{ADDR_PAD{1'b0}}, r_ptr, {`LG_LINE_BYTES{1'b0}}};
   end

endmodule

/* run.sh */
#!/bin/sh
# build and run the cache flush testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module cache_flush_tb \
   -o cache_flush_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/cache_flush_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "TESTBENCH PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* tests/cache_flush_assert.sv */
`timescale 1ns/100ps

module cache_flush_assert
(
   input logic clk,
   input logic reset,
   input logic mem_req_valid,
   input logic mem_rsp_valid,
   input logic in_flush_mode,
   input logic flush_done
);

   logic r_outstanding; // request sent and not yet answered

   always_ff @(posedge clk)
   begin
      if (reset)
         r_outstanding <= 1'b0;
      else if (mem_rsp_valid)
         r_outstanding <= 1'b0;
      else if (mem_req_valid)
         r_outstanding <= 1'b1;
   end

   req_in_flush: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> in_flush_mode)
      else $error("mem_req_valid outside flush mode");

   done_in_flush: assert property (@(posedge clk) disable iff (reset)
      flush_done |-> in_flush_mode && !r_outstanding)
      else $error("flush_done outside flush mode or with a request still open");

   one_outstanding: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> !r_outstanding)
      else $error("second memory request before a response");

endmodule

bind cache_flush_top cache_flush_assert flush_checks
(
   .clk(clk),
   .reset(reset),
   .mem_req_valid(mem_req_valid),
   .mem_rsp_valid(mem_rsp_valid),
   .in_flush_mode(in_flush_mode),
   .flush_done(flush_done)
);

/* tests/cache_flush_tb.sv */
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_flush_tb;

   localparam L1D_TAG_W = `LG_L2_LINES - `LG_L1D_LINES;
   localparam L1I_TAG_W = `LG_FETCH_LINES - `LG_L1I_LINES;
   localparam FLUSH_TIMEOUT = 4000; // cycles

   logic                       clk = 1'b0;
   logic                       reset;
   logic                       store_valid;
   logic [`LG_L2_LINES-1:0]    store_line;
   logic                       fetch_valid;
   logic [`LG_FETCH_LINES-1:0] fetch_line;
   logic                       flush_req_l1d;
   logic                       flush_req_l1i;
   logic                       mem_rsp_valid;
   logic                       fetch_hit_valid;
   logic                       fetch_hit;
   logic                       mem_req_valid;
   logic [`MEM_ADDR_WIDTH-1:0] mem_req_addr;
   logic                       in_flush_mode;
   logic                       flush_done;

   logic [31:0] lcg_state = 32'h46e3;
   int          errors = 0;
   int          timeouts = 0;

   // reference copies of the cache state
   logic [L1D_TAG_W-1:0]            m_l1d_tag [1 << `LG_L1D_LINES];
   logic [(1 << `LG_L1D_LINES)-1:0] m_l1d_dirty;
   logic [L1I_TAG_W-1:0]            m_l1i_tag [1 << `LG_L1I_LINES];
   logic [(1 << `LG_L1I_LINES)-1:0] m_l1i_valid;
   logic [(1 << `LG_L2_LINES)-1:0]  m_l2_dirty;

   logic [31:0] mem_log [$];
   logic [31:0] exp_wb [$];
   logic        prev_fetch; // fetch sent one cycle back
   logic        prev_hit;

   cache_flush_top UUT
   (
      .clk(clk),
      .reset(reset),
      .store_valid(store_valid),
      .store_line(store_line),
      .fetch_valid(fetch_valid),
      .fetch_line(fetch_line),
      .flush_req_l1d(flush_req_l1d),
      .flush_req_l1i(flush_req_l1i),
      .mem_rsp_valid(mem_rsp_valid),
      .fetch_hit_valid(fetch_hit_valid),
      .fetch_hit(fetch_hit),
      .mem_req_valid(mem_req_valid),
      .mem_req_addr(mem_req_addr),
      .in_flush_mode(in_flush_mode),
      .flush_done(flush_done)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 8; // low bits cycle too fast
   endfunction

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         errors++;
         $display("[ERROR] %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   task automatic model_store(input logic [`LG_L2_LINES-1:0] sl);
      logic [`LG_L1D_LINES-1:0] idx;
      logic [L1D_TAG_W-1:0]     tag;
      idx = sl[`LG_L1D_LINES-1:0];
      tag = sl[`LG_L2_LINES-1:`LG_L1D_LINES];
      if (m_l1d_dirty[idx] && (m_l1d_tag[idx] != tag))
         m_l2_dirty[{m_l1d_tag[idx], idx}] = 1'b1; // evicted into L2
      m_l1d_dirty[idx] = 1'b1;
      m_l1d_tag[idx] = tag;
   endtask

   task automatic model_fetch(input logic [`LG_FETCH_LINES-1:0] fl, output logic hit);
      logic [`LG_L1I_LINES-1:0] idx;
      logic [L1I_TAG_W-1:0]     tag;
      idx = fl[`LG_L1I_LINES-1:0];
      tag = fl[`LG_FETCH_LINES-1:`LG_L1I_LINES];
      hit = m_l1i_valid[idx] && (m_l1i_tag[idx] == tag);
      if (!hit)
      begin
         m_l1i_valid[idx] = 1'b1;
         m_l1i_tag[idx] = tag;
      end
   endtask

   // idle outputs checked at the falling edge
   task automatic check_cycle();
      check_equal(32'(fetch_hit_valid), 32'(prev_fetch), "fetch_hit_valid");
      if (prev_fetch)
         check_equal(32'(fetch_hit), 32'(prev_hit), "fetch_hit");
      check_equal(32'(in_flush_mode), 0, "in_flush_mode outside a flush");
      check_equal(32'(mem_req_valid), 0, "mem_req_valid outside a flush");
      check_equal(32'(flush_done), 0, "flush_done outside a flush");
   endtask

   task automatic drive_traffic(input int cycles);
      logic [31:0]                r;
      logic [`LG_FETCH_LINES-1:0] fl;
      logic                       hit;
      repeat (cycles)
      begin
         r = next_rand();
         fl = {1'b0, r[14:8]}; // few tags so that fetches hit
         @(posedge clk);
         store_valid <= r[0];
         store_line <= r[7:2];
         fetch_valid <= r[1];
         fetch_line <= fl;
         if (r[0])
            model_store(r[7:2]);
         hit = 1'b0;
         if (r[1])
            model_fetch(fl, hit);
         @(negedge clk);
         check_cycle();
         prev_fetch = r[1];
         prev_hit = hit;
      end
   endtask

   task automatic run_flush(input logic do_l1d, input logic do_l1i);
      int          cycles;
      logic [31:0] addr;
      @(posedge clk);
      store_valid <= 1'b0;
      fetch_valid <= 1'b0;
      @(negedge clk);
      check_cycle();
      prev_fetch = 1'b0;
      @(posedge clk);
      flush_req_l1d <= do_l1d;
      flush_req_l1i <= do_l1i;
      if (do_l1d)
      begin
         for (int k = 0; k < (1 << `LG_L1D_LINES); k++)
            if (m_l1d_dirty[k])
               m_l2_dirty[{m_l1d_tag[k], k[`LG_L1D_LINES-1:0]}] = 1'b1;
         m_l1d_dirty = '0;
      end
      if (do_l1i)
         m_l1i_valid = '0;
      exp_wb.delete();
      for (int k = 0; k < (1 << `LG_L2_LINES); k++)
         if (m_l2_dirty[k])
         begin
            addr = k << `LG_LINE_BYTES;
            exp_wb.push_back(addr);
         end
      m_l2_dirty = '0;
      mem_log.delete();
      @(negedge clk);
      check_equal(32'(in_flush_mode), 0, "in_flush_mode before the request is taken");
      @(posedge clk);
      flush_req_l1d <= 1'b0;
      flush_req_l1i <= 1'b0;
      @(negedge clk);
      check_equal(32'(in_flush_mode), 1, "in_flush_mode one cycle after the request");
      cycles = 0;
      while (!flush_done && cycles < FLUSH_TIMEOUT)
      begin
         @(negedge clk);
         check_equal(32'(in_flush_mode), 1, "in_flush_mode during the flush");
         cycles++;
      end
      if (!flush_done)
      begin
         timeouts++;
         $display("timeout: flush_done did not pulse within %0d cycles", FLUSH_TIMEOUT);
      end
      else
      begin
         @(negedge clk);
         check_equal(32'(flush_done), 0, "flush_done longer than one cycle");
         check_equal(32'(in_flush_mode), 0, "in_flush_mode after flush_done");
         check_equal(32'(mem_log.size()), 32'(exp_wb.size()), "number of writebacks");
         for (int k = 0; k < mem_log.size() && k < exp_wb.size(); k++)
            check_equal(mem_log[k], exp_wb[k], "writeback address");
      end
   endtask

   // logs each request and answers after 1 to 8 cycles
   initial
   begin
      int wait_cycles;
      mem_rsp_valid = 1'b0;
      forever
      begin
         @(negedge clk);
         if (mem_req_valid)
         begin
            mem_log.push_back(mem_req_addr);
            wait_cycles = 1 + next_rand() % 8;
            repeat (wait_cycles) @(posedge clk);
            mem_rsp_valid <= 1'b1;
            @(posedge clk);
            mem_rsp_valid <= 1'b0;
         end
      end
   end

   initial
   begin
      reset = 1'b1;
      store_valid = 1'b0;
      store_line = '0;
      fetch_valid = 1'b0;
      fetch_line = '0;
      flush_req_l1d = 1'b0;
      flush_req_l1i = 1'b0;
      m_l1d_dirty = '0;
      m_l1i_valid = '0;
      m_l2_dirty = '0;
      prev_fetch = 1'b0;
      prev_hit = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      repeat (8)
      begin
         @(negedge clk);
         check_cycle();
      end
      // flush kinds rotate as both then L1I only then L1D only
      for (int round = 0; round < 12 && timeouts == 0; round++)
      begin
         drive_traffic(20 + next_rand() % 40);
         run_flush(round % 3 != 1, round % 3 != 2);
      end
      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule
